/* exeStage.f */
+incdir+.
exePkg.sv
alu.sv
branchUnit.sv
memWrap.sv
mulDiv.sv
csrUnit.sv
exeStage.sv
tbExeStage.sv

/* Bender.yml */
package:
  name: exeStage

export_include_dirs:
  - .

sources:
  - files:
      - exePkg.sv
      - alu.sv
      - branchUnit.sv
      - memWrap.sv
      - mulDiv.sv
      - csrUnit.sv
      - exeStage.sv
  - target: test
    files:
      - tbExeStage.sv

/* tbExeModel.svh */
`ifndef TB_EXE_MODEL_SVH
`define TB_EXE_MODEL_SVH

logic [7:0] modelMem [4*`DMEM_WORDS]; // byte view of the data memory
logic [`XLEN-1:0] modelCsr [`CSR_NUM];
logic [31:0] rngState = 32'd70352;

function automatic logic [31:0] xorshift32();
	rngState = rngState ^ (rngState << 13);
	rngState = rngState ^ (rngState >> 17);
	rngState = rngState ^ (rngState << 5);
	return rngState;
endfunction

function automatic logic [`XLEN-1:0] aluResult(aluOpT op, logic [`XLEN-1:0] a,
	logic [`XLEN-1:0] b);
	logic [2*`XLEN-1:0] ext;
	int sh;
	sh = b % `XLEN;
	ext = {{`XLEN{a[`XLEN-1]}}, a} >> sh; // sign-filled shift
	case (op)
		aluAdd: return a + b;
		aluSub: return a - b;
		aluSll: return a << sh;
		aluSlt: return ($signed(a) < $signed(b)) ? 1 : 0;
		aluSltu: return (a < b) ? 1 : 0;
		aluXor: return a ^ b;
		aluSrl: return a >> sh;
		aluSra: return ext[`XLEN-1:0];
		aluOr: return a | b;
		aluAnd: return a & b;
		default: return '0;
	endcase
endfunction

function automatic redirectT branchOutcome(issueT op);
	redirectT r;
	logic cond;
	logic signed [`XLEN-1:0] sa;
	logic signed [`XLEN-1:0] sb;
	sa = op.opA;
	sb = op.opB;
	case (op.brOp)
		brEq: cond = (op.opA == op.opB);
		brNe: cond = (op.opA != op.opB);
		brLt: cond = (sa < sb);
		brGe: cond = (sa >= sb);
		brLtu: cond = (op.opA < op.opB);
		brGeu: cond = (op.opA >= op.opB);
		default: cond = 1'b0;
	endcase
	r.taken = op.valid && (cond || op.jmp || op.jmpReg);
	if (op.jmpReg)
		r.target = (op.opA + op.opB) & ~32'd1;
	else if (op.jmp)
		r.target = op.pc + op.jImm;
	else
		r.target = op.pc + op.bImm;
	return r;
endfunction

function automatic logic [`XLEN-1:0] mulDivResult(mulOpT op, logic [`XLEN-1:0] a,
	logic [`XLEN-1:0] b);
	longint sa;
	longint sb;
	longint ua;
	longint ub;
	longint p;
	logic ovf;
	sa = $signed(a);
	sb = $signed(b);
	ua = {32'b0, a};
	ub = {32'b0, b};
	ovf = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
	case (op)
		mdMul: p = sa * sb;
		mdMulh: p = (sa * sb) >> `XLEN;
		mdMulhsu: p = (sa * ub) >> `XLEN;
		mdMulhu: p = (ua * ub) >> `XLEN; // pattern is right even if it wraps
		mdDiv: p = (b == 0) ? -1 : ovf ? sa : sa / sb;
		mdDivu: p = (b == 0) ? -1 : ua / ub;
		mdRem: p = (b == 0) ? sa : ovf ? 0 : sa % sb;
		default: p = (b == 0) ? ua : ua % ub;
	endcase
	return p[`XLEN-1:0];
endfunction

function automatic logic misalignedAt(memOpT op, logic [`XLEN-1:0] addr);
	if (op inside {memLh, memLhu, memSh})
		return addr[0];
	if (op inside {memLw, memSw})
		return addr[1:0] != 2'b00;
	return 1'b0;
endfunction

function automatic void storeBytes(memOpT op, logic [`XLEN-1:0] addr, logic [`XLEN-1:0] data);
	int n;
	int base;
	n = (op == memSb) ? 1 : (op == memSh) ? 2 : 4;
	base = addr % (4*`DMEM_WORDS);
	if (misalignedAt(op, addr))
		return; // dropped, memory untouched
	for (int i = 0; i < n; i++)
		modelMem[base + i] = data[8*i +: 8];
endfunction

function automatic logic [`XLEN-1:0] loadValue(memOpT op, logic [`XLEN-1:0] addr);
	logic [`XLEN-1:0] v;
	int base;
	base = addr % (4*`DMEM_WORDS);
	v = '0;
	if (misalignedAt(op, addr))
		return '0;
	case (op)
		memLb, memLbu: v = {24'b0, modelMem[base]};
		memLh, memLhu: v = {16'b0, modelMem[base+1], modelMem[base]};
		memLw: v = {modelMem[base+3], modelMem[base+2], modelMem[base+1], modelMem[base]};
		default: v = '0;
	endcase
	if (op == memLb && v[7])
		v[31:8] = '1;
	if (op == memLh && v[15])
		v[31:16] = '1;
	return v;
endfunction

// returns the value before the update
function automatic logic [`XLEN-1:0] csrAccess(logic [2:0] f3, logic [1:0] idx,
	logic [`XLEN-1:0] rs1, logic [`XLEN-1:0] imm);
	logic [`XLEN-1:0] old;
	logic [`XLEN-1:0] src;
	old = modelCsr[idx];
	src = (f3 >= 3'd5) ? imm : rs1;
	if (f3 == 3'd1 || f3 == 3'd5)
		modelCsr[idx] = src;
	else if (f3 == 3'd2 || f3 == 3'd6)
		modelCsr[idx] = old | src;
	else if (f3 == 3'd3 || f3 == 3'd7)
		modelCsr[idx] = old & ~src;
	return old;
endfunction

// expected writeback that also advances memory and csr state
function automatic wbT expectWb(issueT op);
	wbT w;
	logic [`XLEN-1:0] memAddr;
	logic [`XLEN-1:0] csrOld;
	logic isStore;
	w = '0;
	w.valid = 1'b1;
	w.we = op.we;
	w.rd = op.rd;
	csrOld = '0;
	isStore = op.memOp inside {memSb, memSh, memSw};
	if (op.csrOp != 3'd0)
		csrOld = csrAccess(op.csrOp, op.csrAddr, op.opA, op.csrImm);
	memAddr = isStore ? (op.opA + op.sImm) : (op.opA + op.opB);
	w.misaligned = misalignedAt(op.memOp, memAddr);
	if (isStore)
		storeBytes(op.memOp, memAddr, op.opB);
	case (op.wbSel)
		wbAlu: w.data = aluResult(op.aluOp, op.opA, op.opB);
		wbLink: w.data = op.pc + 1;
		wbMulDiv: w.data = mulDivResult(op.mulOp, op.opA, op.opB);
		wbUimm: w.data = op.uImm;
		wbMem: w.data = loadValue(op.memOp, memAddr);
		wbAuipc: w.data = op.pc + op.uImm;
		wbCsr: w.data = csrOld;
		default: w.data = '0;
	endcase
	return w;
endfunction

`endif

/* tbExeStage.sv */
`include "exe_cfg.svh"

module tbExeStage;
	import exePkg::*;

	localparam int DrainLimit = 20; // cycles

	logic clk;
	logic nrst;
	issueT issue;
	redirectT redirect;
	wbT wb;

	redirectT expRedir;
	string curName;
	wbT expQ [$];
	int dueQ [$];
	string nameQ [$];
	int cycleCnt = 0;
	int wbErrors = 0;
	int redirErrors = 0;
	int otherErrors = 0;

	`include "tbExeModel.svh"

	exeStage UUT (
		.clk(clk),
		.nrst(nrst),
		.issue(issue),
		.redirect(redirect),
		.wb(wb)
	);

	always #2 clk = ~clk;

	always @(posedge clk)
		cycleCnt <= cycleCnt + 1;

	function automatic issueT newOp();
		issueT op;
		op = '0;
		op.valid = 1'b1;
		return op;
	endfunction

	task automatic sendOp(issueT op, string name);
		@(posedge clk);
		issue <= op;
		expRedir = branchOutcome(op);
		curName = name;
		if (op.valid)
		begin
			expQ.push_back(expectWb(op));
			dueQ.push_back(cycleCnt + 3); // wb visible after the second edge
			nameQ.push_back(name);
		end
	endtask

	// bubble, then wait for everything in flight
	task automatic drain(string phase);
		issueT idle;
		int waited;
		idle = '0;
		waited = 0;
		sendOp(idle, phase);
		while (expQ.size() != 0 && waited < DrainLimit)
		begin
			@(posedge clk);
			waited++;
		end
		assert (expQ.size() == 0)
		else
		begin
			otherErrors++;
			$display("Timeout in %s: %0d writebacks never arrived", phase, expQ.size());
			expQ.delete();
			dueQ.delete();
			nameQ.delete();
		end
	endtask

	always @(negedge clk)
	begin : checkOutputs
		wbT exp;
		int due;
		string name;
		assert (redirect.taken == expRedir.taken
			&& (!expRedir.taken || redirect.target == expRedir.target))
		else
		begin
			redirErrors++;
			$display("ERROR %s: redirect expected taken=%b target=%h, actual taken=%b target=%h",
				curName, expRedir.taken, expRedir.target, redirect.taken, redirect.target);
		end
		if (wb.valid)
		begin
			assert (expQ.size() != 0)
			else
			begin
				otherErrors++;
				$display("Writeback appeared with no operation in flight");
			end
			if (expQ.size() != 0)
			begin
				exp = expQ.pop_front();
				due = dueQ.pop_front();
				name = nameQ.pop_front();
				assert (cycleCnt == due)
				else
				begin
					otherErrors++;
					$display("Writeback of %s came at cycle %0d instead of %0d",
						name, cycleCnt, due);
				end
				assert (wb == exp)
				else
				begin
					wbErrors++;
					$write("ERROR %s: expected we=%b rd=%0d data=%h mis=%b,",
						name, exp.we, exp.rd, exp.data, exp.misaligned);
					$display(" actual we=%b rd=%0d data=%h mis=%b",
						wb.we, wb.rd, wb.data, wb.misaligned);
				end
			end
		end
	end

	initial
	begin
		issueT op;
		logic [31:0] r;
		int sel;
		clk = 1'b0;
		nrst = 1'b0;
		issue = '0;
		expRedir = '0;
		curName = "reset";
		for (int i = 0; i < `CSR_NUM; i++)
			modelCsr[i] = '0;
		repeat (8) @(posedge clk);
		nrst <= 1'b1;
		@(negedge clk);
		assert (wb.valid == 1'b0 && wb.we == 1'b0 && redirect.taken == 1'b0)
		else
		begin
			otherErrors++;
			$display("Outputs not idle after reset");
		end

		// alu, lui, auipc and link results back to back
		for (int i = 0; i < 40; i++)
		begin
			op = newOp();
			r = xorshift32();
			sel = r % 10;
			op.aluOp = aluOpT'(sel[3:0]);
			op.rd = r[8:4];
			op.we = r[9];
			op.opA = xorshift32();
			op.opB = xorshift32();
			op.pc = xorshift32();
			op.uImm = xorshift32() & 32'hFFFF_F000;
			case (i % 4)
				0: op.wbSel = wbAlu;
				1: op.wbSel = wbUimm;
				2: op.wbSel = wbAuipc;
				default: op.wbSel = wbLink;
			endcase
			sendOp(op, "alu");
		end
		drain("alu");

		// six branch kinds, jal and jalr, with some bubbles
		for (int i = 0; i < 48; i++)
		begin
			op = newOp();
			r = xorshift32();
			op.valid = (r % 5) != 0;
			op.opA = xorshift32();
			op.opB = (r[8:7] == 2'b00) ? op.opA : xorshift32(); // force some equal pairs
			op.pc = xorshift32();
			op.bImm = xorshift32();
			op.jImm = xorshift32();
			sel = i % 8;
			if (sel < 6)
				op.brOp = brOpT'(3'(sel + 1));
			else if (sel == 6)
				op.jmp = 1'b1;
			else
				op.jmpReg = 1'b1;
			op.wbSel = wbLink;
			op.we = 1'b1;
			op.rd = r[4:0];
			sendOp(op, "branch");
		end
		drain("branch");

		// first row divides by zero, second row hits the signed overflow
		for (int i = 0; i < 48; i++)
		begin
			op = newOp();
			op.mulOp = mulOpT'(3'(i % 8));
			op.opA = xorshift32();
			op.opB = xorshift32();
			if (i < 8)
				op.opB = '0;
			else if (i < 16)
			begin
				op.opA = 32'h8000_0000;
				op.opB = 32'hFFFF_FFFF;
			end
			op.wbSel = wbMulDiv;
			op.we = 1'b1;
			op.rd = 5'(i);
			sendOp(op, "muldiv");
		end
		drain("muldiv");

		// fill bytes 64..127 so every later load hits known data
		for (int i = 0; i < 16; i++)
		begin
			op = newOp();
			op.memOp = memSw;
			op.opA = 32'h0000_0040 + 4 * i;
			op.opB = xorshift32();
			sendOp(op, "store fill");
		end
		for (int i = 0; i < 30; i++)
		begin
			op = newOp();
			r = xorshift32();
			op.opA = {r[31:10], 10'd64} + r[4:0]; // upper bits exercise the wrap
			op.sImm = xorshift32() % 32;
			op.opB = xorshift32();
			case (r[6:5])
				2'd0: op.memOp = memSb;
				2'd1: op.memOp = memSh;
				default: op.memOp = memSw;
			endcase
			sendOp(op, "store");
		end
		for (int i = 0; i < 40; i++)
		begin
			op = newOp();
			r = xorshift32();
			op.opA = {r[31:10], 10'd64} + r[4:0];
			op.opB = xorshift32() % 32;
			case (r[7:5] % 5)
				0: op.memOp = memLb;
				1: op.memOp = memLh;
				2: op.memOp = memLw;
				3: op.memOp = memLbu;
				default: op.memOp = memLhu;
			endcase
			op.wbSel = wbMem;
			op.we = 1'b1;
			op.rd = r[12:8];
			sendOp(op, "load");
		end
		drain("memory");

		// csr write, set and clear in register and immediate forms
		for (int i = 0; i < 32; i++)
		begin
			op = newOp();
			r = xorshift32();
			sel = r % 3 + 1;
			op.csrOp = sel[2:0] | (r[4] ? 3'd4 : 3'd0);
			op.csrAddr = r[6:5];
			op.opA = xorshift32();
			op.csrImm = {27'b0, r[12:8]};
			op.wbSel = wbCsr;
			op.we = 1'b1;
			op.rd = r[17:13];
			sendOp(op, "csr");
		end
		for (int i = 0; i < `CSR_NUM; i++)
		begin
			op = newOp();
			op.csrOp = 3'd6; // set with zero mask reads only
			op.csrAddr = 2'(i);
			op.wbSel = wbCsr;
			op.we = 1'b1;
			sendOp(op, "csr readback");
		end
		drain("csr");

		$display("Errors: writeback %0d, redirect %0d, other %0d",
			wbErrors, redirErrors, otherErrors);
		if (wbErrors + redirErrors + otherErrors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* exeStage.sv */
`include "exe_cfg.svh"

module exeStage (
	input logic clk,
	input logic nrst,
	input exePkg::issueT issue,
	output exePkg::redirectT redirect,
	output exePkg::wbT wb
);
	import exePkg::*;

	// stage 4
	logic [`XLEN-1:0] aluRes4;
	logic brTaken4;

	// stage 5
	issueT s5;
	logic [`XLEN-1:0] aluRes5;
	logic [`XLEN-1:0] mulDivRes5;
	logic [`XLEN-1:0] csrOld5;

	// stage 6
	logic s6Valid;
	logic s6We;
	logic [`REG_AW-1:0] s6Rd;
	wbSelT s6WbSel;
	logic [`XLEN-1:0] s6AluRes;
	logic [`XLEN-1:0] s6Link;
	logic [`XLEN-1:0] s6MulDiv;
	logic [`XLEN-1:0] s6Uimm;
	logic [`XLEN-1:0] s6Auipc;
	logic [`XLEN-1:0] s6CsrOld;
	logic [`XLEN-1:0] memData6;
	logic memMisal6;

	alu uAlu (
		.opA(issue.opA),
		.opB(issue.opB),
		.aluOp(issue.aluOp),
		.brOp(issue.brOp),
		.result(aluRes4),
		.brTaken(brTaken4)
	);

	// redirect resolves in the issue cycle
	branchUnit uBranch (
		.pc(issue.pc),
		.opA(issue.opA),
		.opB(issue.opB),
		.bImm(issue.bImm),
		.jImm(issue.jImm),
		.jmp(issue.jmp),
		.jmpReg(issue.jmpReg),
		.brTaken(brTaken4),
		.valid(issue.valid),
		.redirect(redirect)
	);

	memWrap uMem (
		.clk(clk),
		.nrst(nrst),
		.valid(issue.valid),
		.memOp(issue.memOp),
		.opA(issue.opA), // base
		.opB(issue.opB), // store data, or load offset
		.sImm(issue.sImm),
		.rdData(memData6),
		.misaligned(memMisal6)
	);

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			s5 <= '0;
			aluRes5 <= '0;
		end
		else
		begin
			s5 <= issue;
			aluRes5 <= aluRes4;
		end
	end

	mulDiv uMulDiv (
		.a(s5.opA),
		.b(s5.opB),
		.mulOp(s5.mulOp),
		.res(mulDivRes5)
	);

	csrUnit uCsr (
		.clk(clk),
		.nrst(nrst),
		.valid(s5.valid),
		.csrOp(s5.csrOp),
		.csrAddr(s5.csrAddr),
		.rs1(s5.opA),
		.imm(s5.csrImm),
		.oldVal(csrOld5)
	);

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			s6Valid <= 1'b0;
			s6We <= 1'b0;
			s6Rd <= '0;
			s6WbSel <= wbAlu;
			s6AluRes <= '0;
			s6Link <= '0;
			s6MulDiv <= '0;
			s6Uimm <= '0;
			s6Auipc <= '0;
			s6CsrOld <= '0;
		end
		else
		begin
			s6Valid <= s5.valid;
			s6We <= s5.we;
			s6Rd <= s5.rd;
			s6WbSel <= s5.wbSel;
			s6AluRes <= aluRes5;
			s6Link <= s5.pc + 1'b1; // pc counts words
			s6MulDiv <= mulDivRes5;
			s6Uimm <= s5.uImm;
			s6Auipc <= s5.pc + s5.uImm;
			s6CsrOld <= csrOld5;
		end
	end

	always_comb
	begin
		wb.valid = s6Valid;
		wb.we = s6Valid & s6We;
		wb.rd = s6Rd;
		wb.misaligned = memMisal6;
		case (s6WbSel)
			wbAlu: wb.data = s6AluRes;
			wbLink: wb.data = s6Link;
			wbMulDiv: wb.data = s6MulDiv;
			wbUimm: wb.data = s6Uimm; // lui
			wbMem: wb.data = memData6;
			wbAuipc: wb.data = s6Auipc;
			wbCsr: wb.data = s6CsrOld;
			default: wb.data = '0;
		endcase
	end

endmodule

/* csrUnit.sv */
`include "exe_cfg.svh"

module csrUnit (
	input logic clk,
	input logic nrst,
	input logic valid,
	input logic [2:0] csrOp,
	input logic [$clog2(`CSR_NUM)-1:0] csrAddr,
	input logic [`XLEN-1:0] rs1,
	input logic [`XLEN-1:0] imm,
	output logic [`XLEN-1:0] oldVal
);
	logic [`XLEN-1:0] csrReg [`CSR_NUM];
	logic [`XLEN-1:0] src;
	logic [`XLEN-1:0] newVal;

	assign oldVal = csrReg[csrAddr];
	assign src = csrOp[2] ? imm : rs1; // funct3 bit 2 picks the immediate forms

	always_comb
	begin
		case (csrOp[1:0])
			2'd1: newVal = src; // csrrw / csrrwi
			2'd2: newVal = oldVal | src; // set
			2'd3: newVal = oldVal & ~src; // clear
			default: newVal = oldVal;
		endcase
	end

	// update lands on the edge closing stage 5
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 0; i < `CSR_NUM; i++)
				csrReg[i] <= '0;
		end
		else if (valid && (csrOp != 3'd0))
		begin
			csrReg[csrAddr] <= newVal;
		end
	end

endmodule

/* mulDiv.sv */
`include "exe_cfg.svh"

module mulDiv (
	input logic [`XLEN-1:0] a,
	input logic [`XLEN-1:0] b,
	input exePkg::mulOpT mulOp,
	output logic [`XLEN-1:0] res
);
	import exePkg::*;

	localparam logic [`XLEN-1:0] MinNeg = {1'b1, {(`XLEN-1){1'b0}}};

	logic [2*`XLEN-1:0] prodSS;
	logic [2*`XLEN-1:0] prodSU;
	logic [2*`XLEN-1:0] prodUU;
	logic [`XLEN-1:0] quotS;
	logic [`XLEN-1:0] remS;
	logic divZero;
	logic divOvf;

	// operands widened so the low 2*XLEN product bits are exact
	assign prodSS = {{`XLEN{a[`XLEN-1]}}, a} * {{`XLEN{b[`XLEN-1]}}, b};
	assign prodSU = {{`XLEN{a[`XLEN-1]}}, a} * {{`XLEN{1'b0}}, b};
	assign prodUU = {{`XLEN{1'b0}}, a} * {{`XLEN{1'b0}}, b};

	assign quotS = $signed(a) / $signed(b); // rounds toward zero
	assign remS = $signed(a) % $signed(b); // takes the sign of a

	assign divZero = (b == '0);
	assign divOvf = (a == MinNeg) && (b == '1); // -2^31 / -1

	always_comb
	begin
		case (mulOp)
			mdMul: res = prodSS[`XLEN-1:0];
			mdMulh: res = prodSS[2*`XLEN-1:`XLEN];
			mdMulhsu: res = prodSU[2*`XLEN-1:`XLEN];
			mdMulhu: res = prodUU[2*`XLEN-1:`XLEN];
			mdDiv: res = divZero ? '1 : divOvf ? a : quotS;
			mdDivu: res = divZero ? '1 : a / b;
			mdRem: res = divZero ? a : divOvf ? '0 : remS;
			mdRemu: res = divZero ? a : a % b;
			default: res = '0;
		endcase
	end

endmodule

/* memWrap.sv */
`include "exe_cfg.svh"

module memWrap (
	input logic clk,
	input logic nrst,
	input logic valid,
	input exePkg::memOpT memOp,
	input logic [`XLEN-1:0] opA,
	input logic [`XLEN-1:0] opB,
	input logic [`XLEN-1:0] sImm,
	output logic [`XLEN-1:0] rdData,
	output logic misaligned
);
	import exePkg::*;

	localparam int IdxW = $clog2(`DMEM_WORDS);

	logic [`XLEN-1:0] mem [`DMEM_WORDS];

	logic [`XLEN-1:0] addr;
	logic [IdxW-1:0] wordIdx;
	logic isStore;
	logic isHalf;
	logic isWord;
	logic misal4;
	logic [3:0] byteEn;
	logic [`XLEN-1:0] wrData;

	memOpT memOp5;
	logic [1:0] byteOff5;
	logic misal5;
	logic [`XLEN-1:0] rdWord5;
	logic [7:0] byteSel5;
	logic [15:0] halfSel5;
	logic [`XLEN-1:0] loadVal5;

	assign isStore = memOp inside {memSb, memSh, memSw};
	assign isHalf = memOp inside {memLh, memLhu, memSh};
	assign isWord = memOp inside {memLw, memSw};

	// stores use S-imm, loads get their offset on opB
	assign addr = isStore ? (opA + sImm) : (opA + opB);
	assign wordIdx = addr[2 +: IdxW]; // wraps at memory size
	assign misal4 = valid & ((isHalf & addr[0]) | (isWord & (addr[1:0] != 2'b00)));

	always_comb
	begin
		case (memOp)
			memSb: byteEn = 4'b0001 << addr[1:0];
			memSh: byteEn = 4'b0011 << {addr[1], 1'b0};
			memSw: byteEn = 4'b1111;
			default: byteEn = 4'b0000;
		endcase
		if (!valid || misal4)
			byteEn = 4'b0000; // misaligned stores are dropped
	end

	// replicate so each lane sees its byte
	assign wrData = (memOp == memSb) ? {4{opB[7:0]}} :
		(memOp == memSh) ? {2{opB[15:0]}} : opB;

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < 4; i++)
			if (byteEn[i])
				mem[wordIdx][8*i +: 8] <= wrData[8*i +: 8];
		rdWord5 <= mem[wordIdx];
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			memOp5 <= memNone;
			byteOff5 <= 2'b00;
			misal5 <= 1'b0;
		end
		else
		begin
			memOp5 <= valid ? memOp : memNone;
			byteOff5 <= addr[1:0];
			misal5 <= misal4;
		end
	end

	// load extension in stage 5
	assign byteSel5 = rdWord5[8*byteOff5 +: 8];
	assign halfSel5 = rdWord5[16*byteOff5[1] +: 16];

	always_comb
	begin
		case (memOp5)
			memLb: loadVal5 = {{(`XLEN-8){byteSel5[7]}}, byteSel5};
			memLbu: loadVal5 = {{(`XLEN-8){1'b0}}, byteSel5};
			memLh: loadVal5 = {{(`XLEN-16){halfSel5[15]}}, halfSel5};
			memLhu: loadVal5 = {{(`XLEN-16){1'b0}}, halfSel5};
			memLw: loadVal5 = rdWord5;
			default: loadVal5 = '0; // stores and non-memory ops
		endcase
		if (misal5)
			loadVal5 = '0;
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			rdData <= '0;
			misaligned <= 1'b0;
		end
		else
		begin
			rdData <= loadVal5;
			misaligned <= misal5;
		end
	end

endmodule

/* branchUnit.sv */
`include "exe_cfg.svh"

module branchUnit (
	input logic [`XLEN-1:0] pc,
	input logic [`XLEN-1:0] opA,
	input logic [`XLEN-1:0] opB,
	input logic [`XLEN-1:0] bImm,
	input logic [`XLEN-1:0] jImm,
	input logic jmp,
	input logic jmpReg,
	input logic brTaken,
	input logic valid,
	output exePkg::redirectT redirect
);
	logic [`XLEN-1:0] regTarget;

	assign regTarget = opA + opB; // rs1 + I-imm

	always_comb
	begin
		if (jmpReg)
			redirect.target = {regTarget[`XLEN-1:1], 1'b0};
		else if (jmp)
			redirect.target = pc + jImm;
		else
			redirect.target = pc + bImm; // only used when the branch is taken
		redirect.taken = valid & (brTaken | jmp | jmpReg);
	end

endmodule

/* alu.sv */
`include "exe_cfg.svh"

module alu (
	input logic [`XLEN-1:0] opA,
	input logic [`XLEN-1:0] opB,
	input exePkg::aluOpT aluOp,
	input exePkg::brOpT brOp,
	output logic [`XLEN-1:0] result,
	output logic brTaken
);
	import exePkg::*;

	logic [$clog2(`XLEN)-1:0] shamt;
	logic isEq;
	logic lessS;
	logic lessU;

	assign shamt = opB[$clog2(`XLEN)-1:0];
	assign isEq = (opA == opB);
	assign lessS = ($signed(opA) < $signed(opB));
	assign lessU = (opA < opB);

	always_comb
	begin
		case (aluOp)
			aluAdd: result = opA + opB;
			aluSub: result = opA - opB;
			aluSll: result = opA << shamt;
			aluSlt: result = {{(`XLEN-1){1'b0}}, lessS};
			aluSltu: result = {{(`XLEN-1){1'b0}}, lessU};
			aluXor: result = opA ^ opB;
			aluSrl: result = opA >> shamt;
			aluSra: result = $signed(opA) >>> shamt; // arithmetic
			aluOr: result = opA | opB;
			aluAnd: result = opA & opB;
			default: result = '0;
		endcase
	end

	// branch compare shares the operand comparators
	always_comb
	begin
		case (brOp)
			brEq: brTaken = isEq;
			brNe: brTaken = !isEq;
			brLt: brTaken = lessS;
			brGe: brTaken = !lessS;
			brLtu: brTaken = lessU;
			brGeu: brTaken = !lessU;
			default: brTaken = 1'b0; // brNone
		endcase
	end

endmodule

/* exePkg.sv */
`include "exe_cfg.svh"

package exePkg;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluSll, aluSlt, aluSltu,
		aluXor, aluSrl, aluSra, aluOr, aluAnd
	} aluOpT;

	typedef enum logic [2:0] {
		brNone, brEq, brNe, brLt, brGe, brLtu, brGeu
	} brOpT;

	typedef enum logic [3:0] {
		memNone, memLb, memLh, memLw, memLbu, memLhu, memSb, memSh, memSw
	} memOpT;

	typedef enum logic [2:0] {
		mdMul, mdMulh, mdMulhsu, mdMulhu, mdDiv, mdDivu, mdRem, mdRemu
	} mulOpT;

	// fixed encoding seen by the writeback mux
	typedef enum logic [2:0] {
		wbAlu = 3'd0,
		wbLink = 3'd1,
		wbMulDiv = 3'd2,
		wbUimm = 3'd3,
		wbMem = 3'd4,
		wbAuipc = 3'd5,
		wbCsr = 3'd6
	} wbSelT;

	typedef struct packed {
		logic valid;
		logic [`XLEN-1:0] opA;
		logic [`XLEN-1:0] opB;
		logic [`REG_AW-1:0] rd;
		logic we;
		aluOpT aluOp;
		brOpT brOp;
		memOpT memOp;
		mulOpT mulOp;
		wbSelT wbSel;
		logic jmp; // jal
		logic jmpReg; // jalr
		logic [`XLEN-1:0] pc; // word index
		logic [`XLEN-1:0] bImm;
		logic [`XLEN-1:0] jImm;
		logic [`XLEN-1:0] uImm;
		logic [`XLEN-1:0] sImm;
		logic [2:0] csrOp; // funct3, zero when not a csr op
		logic [$clog2(`CSR_NUM)-1:0] csrAddr;
		logic [`XLEN-1:0] csrImm; // zero-extended uimm field
	} issueT;

	typedef struct packed {
		logic valid;
		logic we;
		logic [`REG_AW-1:0] rd;
		logic [`XLEN-1:0] data;
		logic misaligned;
	} wbT;

	typedef struct packed {
		logic taken;
		logic [`XLEN-1:0] target;
	} redirectT;

endpackage

/* exe_cfg.svh */
`ifndef EXE_CFG_SVH
`define EXE_CFG_SVH

// datapath width
`define XLEN 32

// architectural register index width
`define REG_AW 5

// data memory depth in 32-bit words
`define DMEM_WORDS 256

`define CSR_NUM 4 // scratch CSRs

`endif
